/* src/pa_defines.svh */
`ifndef PA_DEFINES_SVH
`define PA_DEFINES_SVH

// data word width, bit 0 is the msb
`define PA_WORD_W 16

// one half of an address word
// used by the comparator and by arz
`define PA_HALF_W 8

// increment applied to AR by arm4
`define PA_AR_STEP 4

`endif

/* src/pa_word_pkg.sv */
`include "pa_defines.svh"

package pa_word_pkg;

	// data word, msb first
	typedef logic [0:`PA_WORD_W-1] word_t;

	// adder flags, spare bit kept for a later overflow flag
	typedef struct packed {
		logic carry;
		logic j;
		logic zsum;
		logic spare;
	} alu_flags_t;

	// address word split into halves
	typedef struct packed {
		logic [0:`PA_HALF_W-1] hi;
		logic [0:`PA_HALF_W-1] lo;
	} addr_t;

endpackage

/* src/pa_ctl_pkg.sv */
package pa_ctl_pkg;

	// W bus sources
	typedef enum logic [2:0] {
		w_ir, w_kl, w_rdt, w_ki, w_at, w_ac, w_a, w_none
	} w_sel_e;

	// A bus sources
	typedef enum logic [2:0] {
		a_l, a_ir_short, a_ar, a_ic, a_zero
	} a_sel_e;

	typedef enum logic [2:0] {
		op_add, op_sub, op_and, op_or, op_xor, op_pass_a, op_pass_ac, op_inc_a
	} alu_op_e;

	typedef struct packed {
		alu_op_e op;
		logic cin;
	} alu_ctl_t;

	// strobes and register write controls from the microcontrol
	typedef struct packed {
		logic strob1;
		logic strob2;
		logic as2;
		logic w_ac;
		logic w_ar;
		logic arp1;
		logic arm4;
		logic w_ic;
		logic icp1;
		logic off;
	} reg_strb_t;

endpackage

/* src/bus_w.sv */
`timescale 1ns/1ns
`include "pa_defines.svh"

module bus_w
	import pa_word_pkg::*, pa_ctl_pkg::*;
(
	input w_sel_e w_sel,
	input word_t ir,
	input word_t kl,
	input word_t rdt,
	input word_t bus_ki,
	input word_t at,
	input word_t ac,
	input word_t a,
	output word_t w
);

	always_comb begin
		case (w_sel)
			// low byte of IR only, upper half cleared
			w_ir: w = {{`PA_HALF_W{1'b0}}, ir[`PA_HALF_W:`PA_WORD_W-1]};
			w_kl: w = kl;
			w_rdt: w = rdt;
			w_ki: w = bus_ki;
			w_at: w = at;
			w_ac: w = ac;
			w_a: w = a;
			// idle bus
			w_none: w = '0;
			default: w = '0;
		endcase
	end

endmodule

/* src/bus_a.sv */
`timescale 1ns/1ns
`include "pa_defines.svh"

module bus_a
	import pa_word_pkg::*, pa_ctl_pkg::*;
(
	input a_sel_e a_sel,
	input word_t l,
	input word_t ir,
	input word_t ar,
	input word_t ic,
	output word_t a
);

	// width of the short argument field in IR
	localparam int SHORT_W = 6;

	logic sign;

	// short argument sign sits just above the field
	assign sign = ir[`PA_WORD_W-SHORT_W-1];

	always_comb begin
		case (a_sel)
			a_l: a = l;
			a_ir_short: a = {{(`PA_WORD_W-SHORT_W){sign}}, ir[`PA_WORD_W-SHORT_W:`PA_WORD_W-1]};
			a_ar: a = ar;
			a_ic: a = ic;
			a_zero: a = '0;
			default: a = '0;
		endcase
	end

endmodule

/* src/alu.sv */
`timescale 1ns/1ns
`include "pa_defines.svh"

module alu
	import pa_word_pkg::*, pa_ctl_pkg::*;
(
	input word_t a,
	input word_t ac,
	input alu_ctl_t alu_ctl,
	output word_t f,
	output alu_flags_t flags
);

	// operands widened by one bit to catch the carry out of bit 0
	logic [`PA_WORD_W:0] a_x;
	logic [`PA_WORD_W:0] ac_x;
	logic [`PA_WORD_W:0] cin_x;
	logic [`PA_WORD_W:0] sum;

	assign a_x = {1'b0, a};
	assign ac_x = {1'b0, ac};
	assign cin_x = {{`PA_WORD_W{1'b0}}, alu_ctl.cin};

	always_comb begin
		case (alu_ctl.op)
			op_add: sum = a_x + ac_x + cin_x;
			// a + ~ac + 1, carry set means no borrow
			op_sub: sum = a_x + {1'b0, ~ac} + 1'b1;
			op_and: sum = {1'b0, a & ac};
			op_or: sum = {1'b0, a | ac};
			op_xor: sum = {1'b0, a ^ ac};
			op_pass_a: sum = a_x;
			op_pass_ac: sum = ac_x;
			op_inc_a: sum = a_x + 1'b1;
			default: sum = '0;
		endcase
	end

	assign f = sum[`PA_WORD_W-1:0];

	// carry only from the arithmetic ops
	always_comb begin
		case (alu_ctl.op)
			op_add, op_sub, op_inc_a: flags.carry = sum[`PA_WORD_W];
			default: flags.carry = 1'b0;
		endcase
	end

	assign flags.j = &f;
	assign flags.zsum = ~|f;
	// reserved
	assign flags.spare = 1'b0;

endmodule

/* src/at.sv */
`timescale 1ns/1ns

module at
	import pa_word_pkg::*;
(
	input __clk,
	input arst_n,
	input load,
	input shift,
	input sl,
	input word_t f,
	output word_t at
);

	always_ff @(posedge __clk or negedge arst_n) begin
		if (!arst_n) begin
			at <= '0;
		end else if (load) begin
			at <= f;
		end else if (shift) begin
			// right shift, sl enters the msb
			at <= {sl, at[0:$bits(word_t)-2]};
		end
	end

endmodule

/* src/ar.sv */
`timescale 1ns/1ns
`include "pa_defines.svh"

module ar
	import pa_word_pkg::*;
(
	input __clk,
	input arst_n,
	input load,
	input inc1,
	input inc4,
	input word_t w,
	output word_t ar
);

	// wraps modulo 2^16
	always_ff @(posedge __clk or negedge arst_n) begin
		if (!arst_n) begin
			ar <= '0;
		end else if (load) begin
			ar <= w;
		end else if (inc1) begin
			ar <= ar + word_t'(1);
		end else if (inc4) begin
			ar <= ar + word_t'(`PA_AR_STEP);
		end
	end

endmodule

/* src/ic.sv */
`timescale 1ns/1ns

module ic
	import pa_word_pkg::*;
(
	input __clk,
	input arst_n,
	input clr,
	input load,
	input inc1,
	input word_t w,
	output word_t ic
);

	// clr wins over a load in the same cycle
	always_ff @(posedge __clk or negedge arst_n) begin
		if (!arst_n) begin
			ic <= '0;
		end else if (clr) begin
			ic <= '0;
		end else if (load) begin
			ic <= w;
		end else if (inc1) begin
			ic <= ic + word_t'(1);
		end
	end

endmodule

/* src/pa.sv */
`timescale 1ns/1ns
`include "pa_defines.svh"

module pa
	import pa_word_pkg::*, pa_ctl_pkg::*;
(
	input __clk,
	input arst_n,
	input word_t ir,
	input word_t kl,
	input word_t rdt,
	input word_t bus_ki,
	input word_t l,
	input w_sel_e w_sel,
	input a_sel_e a_sel,
	input alu_ctl_t alu_ctl,
	input reg_strb_t strb,
	input w_dt,
	input wx,
	input eat0,
	input axy,
	input ar_ad,
	input ic_ad,
	input barnb,
	input apb,
	input amb,
	input am1,
	input ap1,
	output word_t w,
	output word_t ddt,
	output word_t dad,
	output alu_flags_t flags,
	output logic s0,
	output logic s_1,
	output logic zs,
	output logic wzi,
	output logic exx,
	output logic exy,
	output logic at15,
	output logic arz,
	output logic zga
);

	word_t a;
	word_t f;
	word_t ac;
	word_t at;
	word_t ar;
	word_t ic;
	addr_t ar_half;
	addr_t kl_half;
	addr_t dad_half;
	logic stroba;
	logic strobb;
	logic w_strobe;
	logic sign_sel;

	// first strobe in the as2-low phase, second in the as2-high phase
	assign stroba = strb.strob1 & ~strb.as2;
	assign strobb = strb.strob2 & strb.as2;
	assign w_strobe = stroba | strobb;

	bus_a bus_a_i (.a_sel(a_sel), .l(l), .ir(ir), .ar(ar), .ic(ic), .a(a));

	alu alu_i (.a(a), .ac(ac), .alu_ctl(alu_ctl), .f(f), .flags(flags));

	bus_w bus_w_i (
		.w_sel(w_sel), .ir(ir), .kl(kl), .rdt(rdt), .bus_ki(bus_ki),
		.at(at), .ac(ac), .a(a), .w(w)
	);

	at at_i (
		.__clk(__clk), .arst_n(arst_n), .load(strb.as2 & strb.strob1),
		.shift(wx & ~strb.as2 & strb.strob1), .sl(eat0), .f(f), .at(at)
	);

	ar ar_i (
		.__clk(__clk), .arst_n(arst_n), .load(strb.w_ar & w_strobe),
		.inc1(strb.arp1 & stroba), .inc4(strb.arm4 & stroba), .w(w), .ar(ar)
	);

	ic ic_i (
		.__clk(__clk), .arst_n(arst_n), .clr(strb.off), .load(strb.w_ic & w_strobe),
		.inc1(strb.icp1 & strb.strob1), .w(w), .ic(ic)
	);

	always_ff @(posedge __clk or negedge arst_n) begin
		if (!arst_n) begin
			ac <= '0;
			wzi <= 1'b0;
		end else begin
			if (strb.w_ac & w_strobe) begin
				ac <= w;
			end
			// adder zero flag
			if (strb.as2 & strb.strob1) begin
				wzi <= zs;
			end
		end
	end

	assign s0 = f[0];
	assign exx = ir[6] ? a[15] : a[0];
	assign exy = axy ? at[15] : a[0];
	assign at15 = at[15];

	// extended sign
	assign sign_sel = (~a[0] & am1) | ((ac[0] ^ a[0]) & apb) |
		(~(ac[0] ^ a[0]) & amb) | (a[0] & ap1);
	assign s_1 = sign_sel ^ flags.carry;
	assign zs = ~s_1 & flags.zsum;

	assign ddt = w_dt ? w : '0;
	assign dad = (ar & {$bits(word_t){ar_ad}}) | (ic & {$bits(word_t){ic_ad}});

	assign ar_half = ar;
	assign arz = |ar_half.hi;

	// breakpoint compare, msb of the high half replaced by barnb
	assign kl_half = kl;
	assign dad_half = dad;
	assign zga = (kl_half.hi == {barnb, dad_half.hi[1:`PA_HALF_W-1]}) &&
		(kl_half.lo == dad_half.lo);

endmodule

/* verif/clk_gen.sv */
`timescale 1ns/1ns

module clk_gen (
	output logic __clk,
	output logic arst_n
);

	// 40 ns period
	initial begin
		__clk = 1'b0;
		forever #20 __clk = ~__clk;
	end

	// reset held for 16 cycles, released just after an edge
	initial begin
		arst_n = 1'b0;
		repeat (16) @(posedge __clk);
		#2 arst_n = 1'b1;
	end

endmodule

/* verif/tb_pa.sv */
`timescale 1ns/1ns

module tb_pa
	import pa_word_pkg::*, pa_ctl_pkg::*;
();

	logic __clk;
	logic arst_n;
	word_t ir, kl, rdt, bus_ki, l;
	w_sel_e w_sel;
	a_sel_e a_sel;
	alu_ctl_t alu_ctl;
	reg_strb_t strb;
	logic w_dt, wx, eat0, axy, ar_ad, ic_ad, barnb, apb, amb, am1, ap1;
	word_t w, ddt, dad;
	alu_flags_t flags;
	logic s0, s_1, zs, wzi, exx, exy, at15, arz, zga;
	int errors;
	int n;
	logic [31:0] rng;

	clk_gen clk_gen_i (.__clk(__clk), .arst_n(arst_n));

	pa pa_i (.*);

	function automatic word_t lcg();
		rng = rng * 32'd1103515245 + 32'd12345;
		return rng[31:16];
	endfunction

	// expected {carry, f} for one ALU operation
	function automatic logic [16:0] alu_model(alu_op_e op, word_t a, word_t b, logic cin);
		logic [16:0] r;
		case (op)
			op_add: r = {1'b0, a} + {1'b0, b} + 17'(cin);
			// carry means no borrow
			op_sub: r = {(a >= b), a - b};
			op_and: r = {1'b0, a & b};
			op_or: r = {1'b0, a | b};
			op_xor: r = {1'b0, a ^ b};
			op_pass_a: r = {1'b0, a};
			op_pass_ac: r = {1'b0, b};
			op_inc_a: r = {1'b0, a} + 17'd1;
			default: r = '0;
		endcase
		return r;
	endfunction

	task automatic report(string msg);
		errors++;
		$display("ERROR t=%0t: %s", $time, msg);
	endtask

	// next drive point 2 ns after the rising edge
	task automatic tick();
		@(posedge __clk);
		#2;
	endtask

	task automatic idle();
		ir = '0;
		kl = '0;
		rdt = '0;
		bus_ki = '0;
		l = '0;
		w_sel = w_none;
		a_sel = a_zero;
		alu_ctl = '0;
		strb = '0;
		{w_dt, wx, eat0, axy, ar_ad, ic_ad, barnb, apb, amb, am1, ap1} = '0;
	endtask

	task automatic load_ac(word_t v);
		tick();
		kl = v;
		w_sel = w_kl;
		strb.strob1 = 1'b1;
		strb.w_ac = 1'b1;
		tick();
		strb = '0;
	endtask

	// stroba load of ar or ic from kl
	task automatic load_reg(logic to_ar, word_t v);
		tick();
		kl = v;
		w_sel = w_kl;
		strb.strob1 = 1'b1;
		strb.w_ar = to_ar;
		strb.w_ic = ~to_ar;
		tick();
		strb = '0;
	endtask

	task automatic read_reg(a_sel_e src, output word_t v);
		tick();
		a_sel = src;
		w_sel = w_a;
		#5;
		v = w;
	endtask

	task automatic expect_ar(word_t exp);
		word_t got;
		read_reg(a_ar, got);
		if (got !== exp) report($sformatf("ar is %h, expected %h", got, exp));
		if (arz !== |exp[0:7]) report($sformatf("arz is %b for ar %h", arz, exp));
	endtask

	task automatic step_ar(logic p1, logic m4);
		tick();
		strb.strob1 = 1'b1;
		strb.arp1 = p1;
		strb.arm4 = m4;
		tick();
		strb = '0;
	endtask

	task automatic reset_state();
		word_t got;
		tick();
		w_sel = w_at;
		#5;
		if (w !== '0) report($sformatf("at after reset is %h", w));
		tick();
		w_sel = w_ac;
		#5;
		if (w !== '0) report($sformatf("ac after reset is %h", w));
		read_reg(a_ar, got);
		if (got !== '0) report($sformatf("ar after reset is %h", got));
		read_reg(a_ic, got);
		if (got !== '0) report($sformatf("ic after reset is %h", got));
		if (wzi !== 1'b0) report("wzi set after reset");
	endtask

	task automatic w_bus_and_ac();
		word_t exp;
		word_t v;
		ir = lcg();
		kl = lcg();
		rdt = lcg();
		bus_ki = lcg();
		l = lcg();
		a_sel = a_l;
		// at and ac still hold their reset value
		for (int s = 0; s < 8; s++) begin
			tick();
			w_sel = w_sel_e'(s);
			#5;
			case (w_sel)
				w_ir: exp = ir & 16'h00ff;
				w_kl: exp = kl;
				w_rdt: exp = rdt;
				w_ki: exp = bus_ki;
				w_a: exp = l;
				default: exp = '0;
			endcase
			if (w !== exp) report($sformatf("w for source %0d is %h, expected %h", s, w, exp));
		end
		tick();
		a_sel = a_ir_short;
		w_sel = w_a;
		#5;
		exp = ir[9] ? (16'hffc0 | (ir & 16'h003f)) : (ir & 16'h003f);
		if (w !== exp) report($sformatf("short argument is %h, expected %h", w, exp));
		v = lcg();
		load_ac(v);
		w_sel = w_ac;
		#5;
		if (w !== v) report($sformatf("ac is %h, expected %h", w, v));
		tick();
		w_dt = 1'b1;
		#5;
		if (ddt !== v) report($sformatf("ddt is %h, expected %h", ddt, v));
		tick();
		w_dt = 1'b0;
		#5;
		if (ddt !== '0) report($sformatf("ddt is %h with w_dt low", ddt));
		// strob2 loads only in the as2 phase
		tick();
		rdt = v ^ 16'h5a5a;
		w_sel = w_rdt;
		strb.strob2 = 1'b1;
		strb.w_ac = 1'b1;
		tick();
		strb = '0;
		w_sel = w_ac;
		#5;
		if (w !== v) report($sformatf("ac changed to %h on strob2 without as2", w));
		tick();
		w_sel = w_rdt;
		strb.strob2 = 1'b1;
		strb.as2 = 1'b1;
		strb.w_ac = 1'b1;
		tick();
		strb = '0;
		w_sel = w_ac;
		#5;
		if (w !== rdt) report($sformatf("ac is %h after strobb, expected %h", w, rdt));
	endtask

	task automatic alu_ops();
		word_t av, bv, rnd;
		logic [16:0] exp;
		logic [16:0] ext;
		for (int i = 0; i < 200; i++) begin
			av = lcg();
			bv = lcg();
			load_ac(bv);
			l = av;
			a_sel = a_l;
			w_sel = w_at;
			for (int op = 0; op < 8; op++) begin
				tick();
				rnd = lcg();
				alu_ctl.op = alu_op_e'(op);
				alu_ctl.cin = rnd[15];
				// sign selection that matches the operation
				apb = (alu_ctl.op == op_add);
				amb = (alu_ctl.op == op_sub);
				ap1 = (alu_ctl.op == op_inc_a);
				// f reaches the outputs through at
				strb.strob1 = 1'b1;
				strb.as2 = 1'b1;
				#5;
				exp = alu_model(alu_ctl.op, av, bv, alu_ctl.cin);
				if (flags.carry !== exp[16] || flags.j !== &exp[15:0] ||
					flags.zsum !== ~|exp[15:0] || s0 !== exp[15])
					report($sformatf("flags %b s0 %b for op %0d a %h ac %h", flags, s0, op, av, bv));
				// sign of the 17-bit sign-extended result
				case (alu_ctl.op)
					op_add: ext = {av[0], av} + {bv[0], bv} + 17'(alu_ctl.cin);
					op_sub: ext = {av[0], av} - {bv[0], bv};
					op_inc_a: ext = {av[0], av} + 17'd1;
					default: ext = '0;
				endcase
				if (s_1 !== ext[16])
					report($sformatf("s_1 %b for op %0d a %h ac %h", s_1, op, av, bv));
				tick();
				strb = '0;
				#5;
				if (w !== exp[15:0])
					report($sformatf("f is %h, expected %h, op %0d a %h ac %h",
						w, exp[15:0], op, av, bv));
			end
		end
		apb = 1'b0;
		amb = 1'b0;
		ap1 = 1'b0;
	endtask

	task automatic counters();
		word_t v, vi, got;
		v = lcg();
		load_reg(1'b1, v);
		expect_ar(v);
		step_ar(1'b1, 1'b0);
		expect_ar(v + 16'd1);
		step_ar(1'b0, 1'b1);
		expect_ar(v + 16'd5);
		// arp1 wins over arm4
		step_ar(1'b1, 1'b1);
		expect_ar(v + 16'd6);
		load_reg(1'b1, 16'hffff);
		step_ar(1'b1, 1'b0);
		expect_ar(16'h0000);
		load_reg(1'b1, 16'hfffe);
		step_ar(1'b0, 1'b1);
		expect_ar(16'h0002);
		vi = lcg();
		load_reg(1'b0, vi);
		tick();
		strb.strob1 = 1'b1;
		strb.icp1 = 1'b1;
		tick();
		strb = '0;
		read_reg(a_ic, got);
		if (got !== vi + 16'd1) report($sformatf("ic is %h, expected %h", got, vi + 16'd1));
		// clear wins over a load in the same cycle
		tick();
		kl = lcg();
		w_sel = w_kl;
		strb.strob1 = 1'b1;
		strb.w_ic = 1'b1;
		strb.off = 1'b1;
		tick();
		strb = '0;
		read_reg(a_ic, got);
		if (got !== '0) report($sformatf("ic is %h after off", got));
		load_reg(1'b0, vi);
		for (int s = 0; s < 4; s++) begin
			tick();
			{ar_ad, ic_ad} = 2'(s);
			#5;
			got = (ar_ad ? 16'h0002 : 16'h0000) | (ic_ad ? vi : 16'h0000);
			if (dad !== got) report($sformatf("dad is %h, expected %h", dad, got));
		end
		tick();
		{ar_ad, ic_ad} = 2'b00;
	endtask

	task automatic at_shift_and_wzi();
		word_t v, exp;
		v = lcg();
		tick();
		l = v;
		a_sel = a_l;
		alu_ctl.op = op_pass_a;
		strb.strob1 = 1'b1;
		strb.as2 = 1'b1;
		tick();
		strb = '0;
		w_sel = w_at;
		#5;
		if (w !== v || at15 !== v[15]) report($sformatf("at is %h, expected %h", w, v));
		exp = v;
		for (int s = 0; s < 2; s++) begin
			tick();
			wx = 1'b1;
			eat0 = (s == 0);
			strb.strob1 = 1'b1;
			tick();
			strb = '0;
			#5;
			exp = {eat0, exp[0:14]};
			if (w !== exp || at15 !== exp[15])
				report($sformatf("at after shift is %h, expected %h", w, exp));
		end
		tick();
		wx = 1'b0;
		eat0 = 1'b0;
		// shift extension bits from a and at
		ir = 16'h0200;
		axy = 1'b1;
		#5;
		if (exx !== v[15] || exy !== exp[15])
			report($sformatf("exx %b exy %b with ir[6] and axy set", exx, exy));
		ir = '0;
		axy = 1'b0;
		#5;
		if (exx !== v[0] || exy !== v[0])
			report($sformatf("exx %b exy %b with ir[6] and axy clear", exx, exy));
		// equal operands with a[0] low give zs high
		v = lcg() & 16'h7fff;
		load_ac(v);
		l = v;
		a_sel = a_l;
		alu_ctl.op = op_sub;
		am1 = 1'b1;
		#5;
		if (zs !== 1'b1 || s_1 !== 1'b0) report($sformatf("zs %b s_1 %b for a %h", zs, s_1, v));
		tick();
		strb.strob1 = 1'b1;
		strb.as2 = 1'b1;
		tick();
		strb = '0;
		#5;
		if (wzi !== 1'b1) report("wzi did not latch a high zs");
		// stroba alone leaves wzi alone
		v = lcg() | 16'h8000;
		load_ac(v);
		l = v;
		#5;
		if (zs !== 1'b0 || s_1 !== 1'b1) report($sformatf("zs %b s_1 %b for a %h", zs, s_1, v));
		if (wzi !== 1'b1) report("wzi changed without as2");
		tick();
		strb.strob1 = 1'b1;
		strb.as2 = 1'b1;
		tick();
		strb = '0;
		am1 = 1'b0;
		#5;
		if (wzi !== 1'b0) report("wzi did not latch a low zs");
	endtask

	task automatic comparator();
		word_t v, rnd, match;
		v = lcg();
		rnd = lcg();
		load_reg(1'b1, v);
		tick();
		ar_ad = 1'b1;
		ic_ad = 1'b0;
		barnb = rnd[0];
		match = {rnd[0], v[1:15]};
		kl = match;
		#5;
		if (zga !== 1'b1) report($sformatf("zga low for kl %h, dad %h", kl, dad));
		// every single-bit flip in both halves
		for (int b = 0; b < 16; b++) begin
			tick();
			kl = match ^ (16'h8000 >> b);
			#5;
			if (zga !== 1'b0) report($sformatf("zga high for kl %h, dad %h", kl, dad));
		end
	endtask

	initial begin
		errors = 0;
		rng = 32'hd120;
		idle();
		for (n = 0; n < 40 && arst_n !== 1'b1; n++) @(posedge __clk);
		if (arst_n !== 1'b1) begin
			$display("reset was never released");
			$display("Some tests failed");
			$finish;
		end else begin
			reset_state();
			w_bus_and_ac();
			alu_ops();
			counters();
			at_shift_and_wzi();
			comparator();
			$display("run finished with %0d errors", errors);
			if (errors == 0) begin
				$display("All tests passed");
			end else begin
				$display("Some tests failed");
			end
			$finish;
		end
	end

	// watchdog
	initial begin
		for (int c = 0; c < 20000; c++) @(posedge __clk);
		$display("timeout, the run did not end within 20000 cycles");
		$display("Some tests failed");
		$finish;
	end

endmodule

/* sim.f */
+incdir+src
src/pa_word_pkg.sv
src/pa_ctl_pkg.sv
src/bus_w.sv
src/bus_a.sv
src/alu.sv
src/at.sv
src/ar.sv
src/ic.sv
src/pa.sv
verif/clk_gen.sv
verif/tb_pa.sv

/* run_sim.sh */
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1
verilator --binary -Wno-fatal --top-module tb_pa -f sim.f -o tb_pa \
	&& ./obj_dir/tb_pa | tee /dev/stderr | grep -q "^All tests passed$" \
	&& echo "simulation run passed" \
	|| { echo "simulation run failed"; exit 1; }
